// ==== design/cacheRdPkg.sv ====
`default_nettype none

package cacheRdPkg;

    localparam int ADDR_BITS = 10;
    localparam int CWIDTH = 32;
    localparam int IWIDTH = 128;
    localparam int WNUM = 4;
    localparam int LEN_BITS = 8;
    localparam int ID_LEN = 2;
    localparam int BUF_LEN = 8;
    // 16 words per cache line
    localparam int LINE_WORDS_E = 4;

    localparam int WIDX_BITS = $clog2(WNUM);
    localparam int PTR_BITS = $clog2(BUF_LEN);
    localparam int FREE_BITS = $clog2(BUF_LEN) + 1;
    // Up to three accumulated words plus two MMIO entries
    localparam int FLIGHT_BITS = 4;
    localparam int CREDIT_BITS = FREE_BITS + WIDX_BITS;

    typedef enum logic {
        KIND_CACHE,
        KIND_MMIO
    } reqKind;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_READ,
        SEQ_HOLD
    } seqState;

    // len holds the number of words minus one
    typedef struct packed {
        logic [ID_LEN-1:0] id;
        logic [ADDR_BITS-1:0] addr;
        logic [LEN_BITS-1:0] len;
        reqKind kind;
        logic [31:0] mmioData;
    } readReq;

    typedef struct packed {
        logic valid;
        logic [ID_LEN-1:0] id;
        reqKind kind;
        logic last;
        logic [31:0] mmioData;
    } readMeta;

    typedef struct packed {
        logic [IWIDTH-1:0] data;
        logic [ID_LEN-1:0] id;
        logic last;
    } beat;

endpackage

`default_nettype wire

// ==== design/cacheDataArray.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheDataArray import cacheRdPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic rdEn,
    input  logic [ADDR_BITS-1:0] rdAddr,
    output logic rdReady,
    output logic [CWIDTH-1:0] rdData,
    input  logic fillEn,
    input  logic [ADDR_BITS-1:0] fillAddr,
    input  logic [CWIDTH-1:0] fillData
);

    logic [CWIDTH-1:0] mem [0:(1 << ADDR_BITS) - 1];
    logic [ADDR_BITS-1:0] addrQ;

    // Fill owns the port for the whole cycle
    assign rdReady = !fillEn;

    always_ff @(posedge clk) begin
        if (fillEn) begin
            mem[fillAddr] <= fillData;
        end
    end

    // Stage one latches the address, stage two the word
    always_ff @(posedge clk) begin
        if (rdEn && rdReady) begin
            addrQ <= rdAddr;
        end
    end

    always_ff @(posedge clk) begin
        rdData <= mem[addrQ];
    end

    // A stalled read is retried next cycle at the same address
    stallHold: assert property (@(posedge clk) disable iff (rst)
        rdEn && !rdReady |=> rdEn && $stable(rdAddr))
        else $error("read withdrawn or moved during a fill stall");

endmodule

`default_nettype wire

// ==== design/wordCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wordCounter import cacheRdPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic advance,
    input  logic [ADDR_BITS-1:0] startAddr,
    input  logic [LEN_BITS-1:0] len,
    output logic [ADDR_BITS-1:0] addr,
    output logic last
);

    logic [LEN_BITS-1:0] progress;
    logic [LINE_WORDS_E-1:0] lineOffset;

    always_ff @(posedge clk) begin
        if (rst) begin
            progress <= '0;
        end else if (start) begin
            progress <= '0;
        end else if (advance) begin
            progress <= progress + 1'b1;
        end
    end

    // Offset wraps inside the line, line bits come from the start address
    assign lineOffset = startAddr[LINE_WORDS_E-1:0] + progress[LINE_WORDS_E-1:0];
    assign addr = {startAddr[ADDR_BITS-1:LINE_WORDS_E], lineOffset};

    assign last = (progress == len);

endmodule

`default_nettype wire

// ==== design/readSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module readSequencer import cacheRdPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    input  readReq req,
    output logic reqReady,
    output logic rdEn,
    output logic [ADDR_BITS-1:0] rdAddr,
    input  logic rdReady,
    input  logic [FREE_BITS-1:0] freeSlots,
    input  logic [FLIGHT_BITS-1:0] inFlight,
    output readMeta issueMeta,
    output logic readDone,
    output logic [ID_LEN-1:0] readDoneId
);

    seqState state;
    seqState stateNext;
    readReq cur;
    readReq queued;
    logic queuedValid;
    logic active;
    logic isMmio;
    logic creditOk;
    logic issue;
    logic readSucc;
    logic metaLast;
    logic lastSucc;
    logic accept;
    logic loadCur;
    logic queueLoad;
    logic wcLast;
    logic [CREDIT_BITS-1:0] credit;

    wordCounter progressCtr (
        .clk(clk),
        .rst(rst),
        .start(loadCur),
        .advance(readSucc),
        .startAddr(cur.addr),
        .len(cur.len),
        .addr(rdAddr),
        .last(wcLast)
    );

    assign active = (state != SEQ_IDLE);
    assign isMmio = (cur.kind == KIND_MMIO);

    // Each free FIFO slot covers one beat of four words
    assign credit = CREDIT_BITS'(freeSlots) * CREDIT_BITS'(WNUM);
    assign creditOk = credit > CREDIT_BITS'(inFlight);

    assign issue = active && creditOk;
    assign readSucc = issue && (rdReady || isMmio);
    assign metaLast = wcLast || isMmio;
    assign lastSucc = readSucc && metaLast;

    assign reqReady = !queuedValid || lastSucc;
    assign accept = reqValid && reqReady;
    assign loadCur = (!active && accept) || (lastSucc && (queuedValid || accept));
    assign queueLoad = accept && active && (queuedValid || !lastSucc);

    assign rdEn = issue && !isMmio;

    assign issueMeta = '{valid: readSucc, id: cur.id, kind: cur.kind,
                         last: metaLast, mmioData: cur.mmioData};

    // Array may reuse the location once it has been read
    assign readDone = readSucc && !isMmio;
    assign readDoneId = cur.id;

    always_comb begin
        stateNext = state;
        case (state)
            SEQ_IDLE: begin
                if (accept) begin
                    stateNext = SEQ_READ;
                end
            end
            SEQ_READ, SEQ_HOLD: begin
                if (lastSucc && !queuedValid && !accept) begin
                    stateNext = SEQ_IDLE;
                end else if (readSucc) begin
                    stateNext = SEQ_READ;
                end else begin
                    stateNext = SEQ_HOLD;
                end
            end
            default: stateNext = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            queuedValid <= 1'b0;
        end else begin
            state <= stateNext;
            if (queueLoad) begin
                queuedValid <= 1'b1;
            end else if (lastSucc && queuedValid) begin
                queuedValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadCur) begin
            cur <= queuedValid ? queued : req;
        end
        if (queueLoad) begin
            queued <= req;
        end
    end

    lenMultiple: assert property (@(posedge clk) disable iff (rst)
        accept && req.kind == KIND_CACHE |-> req.len[WIDX_BITS-1:0] == WIDX_BITS'(WNUM - 1))
        else $error("cache request length is not a multiple of four words");

endmodule

`default_nettype wire

// ==== design/beatPacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module beatPacker import cacheRdPkg::*; (
    input  logic clk,
    input  logic rst,
    input  readMeta issueMeta,
    input  logic [CWIDTH-1:0] rdData,
    output logic [FLIGHT_BITS-1:0] inFlight,
    output logic fifoWrite,
    output beat fifoBeat
);

    readMeta [1:0] metaSr;
    readMeta head;
    logic [WNUM-2:0][CWIDTH-1:0] acc;
    logic [WIDX_BITS-1:0] accIdx;
    logic doAcc;

    function automatic logic [FLIGHT_BITS-1:0] wordWeight(input readMeta m);
        logic [FLIGHT_BITS-1:0] w;
        w = '0;
        if (m.valid) begin
            w = (m.kind == KIND_MMIO) ? FLIGHT_BITS'(WNUM) : FLIGHT_BITS'(1);
        end
        return w;
    endfunction

    // Words still owed to the FIFO
    // an MMIO entry takes a whole slot so it weighs as four words
    assign inFlight = FLIGHT_BITS'(accIdx) + wordWeight(metaSr[0]) + wordWeight(metaSr[1]);

    // Second stage lines up with rdData
    assign head = metaSr[1];

    always_comb begin
        fifoWrite = 1'b0;
        fifoBeat = '0;
        doAcc = 1'b0;
        if (head.valid) begin
            fifoBeat.id = head.id;
            fifoBeat.last = head.last;
            if (head.kind == KIND_MMIO) begin
                fifoWrite = 1'b1;
                fifoBeat.data = IWIDTH'(head.mmioData);
            end else if (accIdx == WIDX_BITS'(WNUM - 1)) begin
                fifoWrite = 1'b1;
                fifoBeat.data = {rdData, acc};
            end else begin
                doAcc = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            metaSr <= '0;
            accIdx <= '0;
        end else begin
            metaSr <= {metaSr[0], issueMeta};
            if (doAcc) begin
                accIdx <= accIdx + 1'b1;
            end else if (fifoWrite && head.kind == KIND_CACHE) begin
                accIdx <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doAcc) begin
            acc[accIdx] <= rdData;
        end
    end

    // Transfer end must coincide with a beat boundary
    lastOnBeat: assert property (@(posedge clk) disable iff (rst)
        head.valid && head.kind == KIND_CACHE && accIdx != WIDX_BITS'(WNUM - 1) |-> !head.last)
        else $error("last flag on a partial beat");

endmodule

`default_nettype wire

// ==== design/beatFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module beatFifo import cacheRdPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic wrEn,
    input  beat wrBeat,
    output logic [FREE_BITS-1:0] freeSlots,
    output logic outValid,
    output beat outBeat,
    input  logic outReady
);

    beat mem [0:BUF_LEN-1];
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS-1:0] rdPtr;
    logic [FREE_BITS-1:0] count;
    logic pop;

    assign outValid = (count != '0);
    assign outBeat = mem[rdPtr];
    assign pop = outValid && outReady;

    assign freeSlots = FREE_BITS'(BUF_LEN) - count;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= wrBeat;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({wrEn, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Upstream credit keeps the buffer from overflowing
    noOverflow: assert property (@(posedge clk) disable iff (rst)
        wrEn |-> count != FREE_BITS'(BUF_LEN))
        else $error("beat written into a full FIFO");

endmodule

`default_nettype wire

// ==== design/cacheReadTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheReadTop import cacheRdPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic reqValid,
    input  readReq req,
    output logic reqReady,
    output logic outValid,
    output beat outBeat,
    input  logic outReady,
    output logic readDone,
    output logic [ID_LEN-1:0] readDoneId,
    input  logic fillEn,
    input  logic [ADDR_BITS-1:0] fillAddr,
    input  logic [CWIDTH-1:0] fillData
);

    logic rdEn;
    logic rdReady;
    logic [ADDR_BITS-1:0] rdAddr;
    logic [CWIDTH-1:0] rdData;
    logic [FREE_BITS-1:0] freeSlots;
    logic [FLIGHT_BITS-1:0] inFlight;
    readMeta issueMeta;
    logic fifoWrite;
    beat fifoBeat;

    readSequencer sequencer (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .req(req),
        .reqReady(reqReady),
        .rdEn(rdEn),
        .rdAddr(rdAddr),
        .rdReady(rdReady),
        .freeSlots(freeSlots),
        .inFlight(inFlight),
        .issueMeta(issueMeta),
        .readDone(readDone),
        .readDoneId(readDoneId)
    );

    cacheDataArray dataArray (
        .clk(clk),
        .rst(rst),
        .rdEn(rdEn),
        .rdAddr(rdAddr),
        .rdReady(rdReady),
        .rdData(rdData),
        .fillEn(fillEn),
        .fillAddr(fillAddr),
        .fillData(fillData)
    );

    beatPacker packer (
        .clk(clk),
        .rst(rst),
        .issueMeta(issueMeta),
        .rdData(rdData),
        .inFlight(inFlight),
        .fifoWrite(fifoWrite),
        .fifoBeat(fifoBeat)
    );

    beatFifo outFifo (
        .clk(clk),
        .rst(rst),
        .wrEn(fifoWrite),
        .wrBeat(fifoBeat),
        .freeSlots(freeSlots),
        .outValid(outValid),
        .outBeat(outBeat),
        .outReady(outReady)
    );

endmodule

`default_nettype wire

// ==== sim/cacheReadTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheReadTb import cacheRdPkg::*; ();

    localparam int WAIT_LIMIT = 4000;

    logic clk;
    logic rst;
    logic reqValid;
    readReq req;
    logic reqReady;
    logic outValid;
    beat outBeat;
    logic outReady;
    logic readDone;
    logic [ID_LEN-1:0] readDoneId;
    logic fillEn;
    logic [ADDR_BITS-1:0] fillAddr;
    logic [CWIDTH-1:0] fillData;

    logic [CWIDTH-1:0] mirror [0:(1 << ADDR_BITS) - 1];
    logic [31:0] rngState;
    beat gotBeats[$];
    beat expBeats[$];
    logic [ID_LEN-1:0] gotDoneIds[$];
    logic [ID_LEN-1:0] expDoneIds[$];
    int beatsChecked;
    int donesChecked;

    cacheReadTop uut (
        .clk(clk),
        .rst(rst),
        .reqValid(reqValid),
        .req(req),
        .reqReady(reqReady),
        .outValid(outValid),
        .outBeat(outBeat),
        .outReady(outReady),
        .readDone(readDone),
        .readDoneId(readDoneId),
        .fillEn(fillEn),
        .fillAddr(fillAddr),
        .fillData(fillData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Handshakes are judged mid-cycle, once inputs and outputs have settled
    always @(negedge clk) begin
        if (!rst && outValid && outReady) begin
            gotBeats.push_back(outBeat);
        end
        if (!rst && readDone) begin
            gotDoneIds.push_back(readDoneId);
        end
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic readReq makeReq(input logic [ID_LEN-1:0] id,
                                       input logic [ADDR_BITS-1:0] addr, input int words,
                                       input reqKind kind, input logic [31:0] mmio);
        readReq m;
        m.id = id;
        m.addr = addr;
        m.len = LEN_BITS'(words - 1);
        m.kind = kind;
        m.mmioData = mmio;
        return m;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkBeat(input beat got, input beat exp, input string name);
        if (got !== exp) begin
            failRun($sformatf({"CHECK FAILED at %0t: %s got data=%h id=%0d last=%b,",
                               " expected data=%h id=%0d last=%b"}, $time, name,
                              got.data, got.id, got.last, exp.data, exp.id, exp.last));
        end
    endtask

    task automatic checkId(input logic [ID_LEN-1:0] got, input logic [ID_LEN-1:0] exp,
                           input string name);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t: %s got %0d, expected %0d",
                              $time, name, got, exp));
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic loadArray();
        for (int a = 0; a < (1 << ADDR_BITS); a++) begin
            fillEn = 1'b1;
            fillAddr = ADDR_BITS'(a);
            fillData = nextRandom();
            mirror[ADDR_BITS'(a)] = fillData;
            nextCycle();
        end
        fillEn = 1'b0;
    endtask

    // Words wrap inside the 16-word line, word 0 of a beat sits in the low bits
    task automatic expectTransfer(input readReq r);
        beat b;
        logic [ADDR_BITS-1:0] a;
        b = '0;
        b.id = r.id;
        if (r.kind == KIND_MMIO) begin
            b.data = {{(IWIDTH - CWIDTH){1'b0}}, r.mmioData};
            b.last = 1'b1;
            expBeats.push_back(b);
        end else begin
            for (int w = 0; w <= int'(r.len); w++) begin
                a = {r.addr[ADDR_BITS-1:LINE_WORDS_E],
                     r.addr[LINE_WORDS_E-1:0] + LINE_WORDS_E'(w)};
                b.data = {mirror[a], b.data[IWIDTH-1:CWIDTH]};
                expDoneIds.push_back(r.id);
                if (w % WNUM == WNUM - 1) begin
                    b.last = (w == int'(r.len));
                    expBeats.push_back(b);
                end
            end
        end
    endtask

    task automatic sendReq(input readReq r);
        int waited;
        waited = 0;
        expectTransfer(r);
        reqValid = 1'b1;
        req = r;
        @(negedge clk);
        while (!reqReady) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                failRun("request was never accepted");
            end
            nextCycle();
            @(negedge clk);
        end
        nextCycle();
        reqValid = 1'b0;
    endtask

    task automatic drainAndCompare();
        int waited;
        int quiet;
        waited = 0;
        quiet = 0;
        // Stray beats would show up within a few cycles of the last one
        while (gotBeats.size() < expBeats.size() || quiet < 8) begin
            @(negedge clk);
            quiet = outValid ? 0 : quiet + 1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                failRun($sformatf("timed out with %0d of %0d beats received",
                                  gotBeats.size(), expBeats.size()));
            end
        end
        nextCycle();
        if (gotBeats.size() != expBeats.size()) begin
            failRun($sformatf("received %0d beats, expected %0d",
                              gotBeats.size(), expBeats.size()));
        end
        if (gotDoneIds.size() != expDoneIds.size()) begin
            failRun($sformatf("saw %0d readDone pulses, expected %0d",
                              gotDoneIds.size(), expDoneIds.size()));
        end
        for (int i = beatsChecked; i < expBeats.size(); i++) begin
            checkBeat(gotBeats[i], expBeats[i], "outBeat");
        end
        for (int i = donesChecked; i < expDoneIds.size(); i++) begin
            checkId(gotDoneIds[i], expDoneIds[i], "readDoneId");
        end
        beatsChecked = expBeats.size();
        donesChecked = expDoneIds.size();
    endtask

    task automatic testReset();
        @(negedge clk);
        if (outValid !== 1'b0) begin
            failRun($sformatf("CHECK FAILED at %0t: outValid got %b, expected 0", $time, outValid));
        end
        if (readDone !== 1'b0) begin
            failRun($sformatf("CHECK FAILED at %0t: readDone got %b, expected 0", $time, readDone));
        end
        if (reqReady !== 1'b1) begin
            failRun($sformatf("CHECK FAILED at %0t: reqReady got %b, expected 1", $time, reqReady));
        end
        nextCycle();
    endtask

    task automatic testWrapRead();
        sendReq(makeReq(2'd1, 10'h2A6, 16, KIND_CACHE, 32'd0));
        drainAndCompare();
    endtask

    task automatic testMmio();
        sendReq(makeReq(2'd2, 10'h000, 1, KIND_MMIO, 32'h8421_7BDE));
        drainAndCompare();
    endtask

    // The second request waits in the queued slot, the third waits on reqReady
    task automatic testQueued();
        sendReq(makeReq(2'd0, 10'h3F4, 8, KIND_CACHE, 32'd0));
        sendReq(makeReq(2'd1, 10'h155, 1, KIND_MMIO, 32'h5A3C_91E7));
        sendReq(makeReq(2'd2, 10'h0C9, 12, KIND_CACHE, 32'd0));
        drainAndCompare();
    endtask

    // Low periods run long enough to fill the FIFO and stall on credit
    task automatic testStress();
        logic [31:0] r;
        int waited;
        int lowLeft;
        int fillLeft;
        waited = 0;
        lowLeft = 0;
        fillLeft = 0;
        sendReq(makeReq(2'd3, 10'h107, 64, KIND_CACHE, 32'd0));
        while (gotBeats.size() < expBeats.size()) begin
            r = nextRandom();
            if (lowLeft == 0 && r[2:0] == 3'd0) begin
                lowLeft = int'(r[8:3]) + 1;
            end
            if (fillLeft == 0 && r[15:13] == 3'd0) begin
                fillLeft = int'(r[10:9]) + 1;
            end
            outReady = (lowLeft == 0);
            // Fill rewrites the current contents so only the stall matters
            fillEn = (fillLeft != 0);
            fillAddr = r[31:22];
            fillData = mirror[r[31:22]];
            lowLeft = (lowLeft > 0) ? lowLeft - 1 : 0;
            fillLeft = (fillLeft > 0) ? fillLeft - 1 : 0;
            nextCycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                failRun("long read under back-pressure did not complete");
            end
        end
        fillEn = 1'b0;
        outReady = 1'b1;
        drainAndCompare();
    endtask

    initial begin
        rst = 1'b1;
        reqValid = 1'b0;
        req = '0;
        outReady = 1'b0;
        fillEn = 1'b0;
        fillAddr = '0;
        fillData = '0;
        rngState = 32'd16667;
        beatsChecked = 0;
        donesChecked = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        testReset();
        loadArray();
        outReady = 1'b1;
        testWrapRead();
        testMmio();
        testQueued();
        testStress();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cacheReadTop.f ====
design/cacheRdPkg.sv
design/cacheDataArray.sv
design/wordCounter.sv
design/readSequencer.sv
design/beatPacker.sv
design/beatFifo.sv
design/cacheReadTop.sv
sim/cacheReadTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches the log for the pass line
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module cacheReadTb \
    -f cacheReadTop.f --Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$logFile"; then
    exit 0
fi
echo "pass line not found in $logFile"
exit 1
